// File: source/ahbBusPkg.sv
// AHB bus shared definitions

package ahbBusPkg;

    // Data bus width
    parameter int dataWidth = 32;

    // HSIZE codes used here
    parameter logic [2:0] sizeByte = 3'd0;
    parameter logic [2:0] sizeHalf = 3'd1;
    parameter logic [2:0] sizeWord = 3'd2;

    // Address multiplexer select codes
    parameter logic [1:0] selT = 2'd0;
    parameter logic [1:0] selM = 2'd1;
    parameter logic [1:0] selF = 2'd2;

    // One master's address phase
    // T and F drive write low and size word
    typedef struct packed {
        logic        request;
        logic        write;
        logic [2:0]  size;
        logic [31:0] addr;
    } masterReq;

endpackage

// File: source/ahbArbiterController.sv
// Three-master AHB arbiter control

`timescale 1ns/1ps

module ahbArbiterController (
    input  logic       clk,
    input  logic       reset,
    input  logic       hready,
    input  logic       requestT,
    input  logic       requestM,
    input  logic       requestF,
    input  logic       writeM,
    input  logic [2:0] sizeM,
    output logic       grantT,
    output logic       grantM,
    output logic       grantF,
    output logic       readyT,
    output logic       readyM,
    output logic       readyF,
    output logic       busRequest,
    output logic       hwrite,
    output logic [1:0] addrSel,
    output logic [2:0] hsize
);

    // Single, or the later members of a fixed sequence
    // Priority is T over M over F
    typedef enum logic [2:0] {
        stSingle,
        stTmfM,
        stTmfF,
        stMf,
        stTm,
        stTf
    } arbState;

    arbState state, nextState;

    // Address-phase selection
    logic selectT, selectM, selectF;
    // Data-phase owner
    logic prevT, prevM, prevF;

    assign busRequest = requestT | requestM | requestF;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stSingle;
        end else if (hready) begin
            state <= nextState;
        end
    end

    // First member goes out from single, the rest follow one per phase
    always_comb begin
        nextState = stSingle;
        case (state)
            stSingle: begin
                if (requestT && requestM && requestF) begin
                    nextState = stTmfM;
                end else if (requestT && requestM) begin
                    nextState = stTm;
                end else if (requestT && requestF) begin
                    nextState = stTf;
                end else if (requestM && requestF) begin
                    nextState = stMf;
                end
            end
            stTmfM:  nextState = stTmfF;
            default: nextState = stSingle;
        endcase
    end

    // Highest requester in single, fixed member otherwise
    assign selectT = (state == stSingle) & requestT;
    assign selectM = ((state == stSingle) & ~requestT & requestM) |
                     (state == stTmfM) | (state == stTm);
    assign selectF = ((state == stSingle) & ~requestT & ~requestM & requestF) |
                     (state == stTmfF) | (state == stMf) | (state == stTf);

    // Grant tells the master its address is on the bus
    assign grantT = selectT;
    assign grantM = selectM;
    assign grantF = selectF;

    always_comb begin
        case ({selectT, selectM, selectF})
            3'b010:  addrSel = ahbBusPkg::selM;
            3'b001:  addrSel = ahbBusPkg::selF;
            default: addrSel = ahbBusPkg::selT;
        endcase
    end

    // Only M writes or uses a narrow size
    assign hwrite = writeM & selectM;
    assign hsize  = selectM ? sizeM : ahbBusPkg::sizeWord;

    // Remember who owned the accepted address phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {prevT, prevM, prevF} <= 3'b000;
        end else if (hready) begin
            {prevT, prevM, prevF} <= {selectT, selectM, selectF};
        end
    end

    // Data phase ends for its owner when the slave is ready
    assign readyT = prevT & hready;
    assign readyM = prevM & hready;
    assign readyF = prevF & hready;

endmodule

// File: source/ahbArbiter.sv
// AHB-Lite three-way arbiter

`timescale 1ns/1ps

module ahbArbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  ahbBusPkg::masterReq                reqT,
    input  ahbBusPkg::masterReq                reqM,
    input  ahbBusPkg::masterReq                reqF,
    input  logic [ahbBusPkg::dataWidth-1:0]    hwDataM,
    input  logic                               hready,
    output logic                               grantT,
    output logic                               grantM,
    output logic                               grantF,
    output logic                               readyT,
    output logic                               readyM,
    output logic                               readyF,
    output logic [31:0]                        haddr,
    output logic                               htrans,
    output logic                               hwrite,
    output logic [2:0]                         hsize,
    output logic [ahbBusPkg::dataWidth-1:0]    hwData
);

    logic [1:0] addrSel;
    logic       busRequest;

    ahbArbiterController controller (
        .clk        (clk),
        .reset      (reset),
        .hready     (hready),
        .requestT   (reqT.request),
        .requestM   (reqM.request),
        .requestF   (reqF.request),
        .writeM     (reqM.write),
        .sizeM      (reqM.size),
        .grantT     (grantT),
        .grantM     (grantM),
        .grantF     (grantF),
        .readyT     (readyT),
        .readyM     (readyM),
        .readyF     (readyF),
        .busRequest (busRequest),
        .hwrite     (hwrite),
        .addrSel    (addrSel),
        .hsize      (hsize)
    );

    // Address multiplexer
    always_comb begin
        case (addrSel)
            ahbBusPkg::selM: haddr = reqM.addr;
            ahbBusPkg::selF: haddr = reqF.addr;
            default:         haddr = reqT.addr;
        endcase
    end

    // Nonsequential whenever anyone asks, idle otherwise
    assign htrans = busRequest;

    // M is the only writer
    assign hwData = hwDataM;

endmodule

// File: source/ahbWaitMemory.sv
// AHB-Lite memory with wait states

`timescale 1ns/1ps

module ahbWaitMemory #(
    parameter int waitStates = 2,
    parameter int memWords   = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [31:0]                     haddr,
    input  logic                            htrans,
    input  logic                            hwrite,
    input  logic [2:0]                      hsize,
    input  logic [ahbBusPkg::dataWidth-1:0] hwData,
    output logic                            hready,
    output logic [ahbBusPkg::dataWidth-1:0] hrData
);

    localparam int idxWidth = $clog2(memWords);
    // Counter needs at least one bit when there are no waits
    localparam int cntWidth = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

    logic [ahbBusPkg::dataWidth-1:0] mem [memWords];

    // Transfer in its data phase
    logic                active;
    logic [cntWidth-1:0] waitCnt;
    logic                accept;
    logic                dataDone;

    // Captured address phase
    logic [idxWidth-1:0] dataIndex;
    logic [1:0]          dataLane;
    logic                dataWrite;
    logic [2:0]          dataSize;
    logic [3:0]          byteEn;

    assign dataDone = active & (waitCnt == '0);
    // Idle bus or last data cycle
    assign hready   = ~active | dataDone;
    assign accept   = htrans & hready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active  <= 1'b0;
            waitCnt <= '0;
        end else if (hready) begin
            // Next transfer starts as the current one ends
            active  <= accept;
            waitCnt <= cntWidth'(waitStates);
        end else begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    // Address bits above the depth drop out here
    always_ff @(posedge clk) begin
        if (accept) begin
            dataIndex <= haddr[idxWidth+1:2];
            dataLane  <= haddr[1:0];
            dataWrite <= hwrite;
            dataSize  <= hsize;
        end
    end

    // Lanes touched by size and low address bits
    always_comb begin
        case (dataSize)
            ahbBusPkg::sizeByte: byteEn = 4'b0001 << dataLane;
            ahbBusPkg::sizeHalf: byteEn = dataLane[1] ? 4'b1100 : 4'b0011;
            ahbBusPkg::sizeWord: byteEn = 4'b1111;
            default:             byteEn = 4'b0000;
        endcase
    end

    // Write data is valid in the last data cycle
    always_ff @(posedge clk) begin
        if (dataDone && dataWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    mem[dataIndex][8*lane +: 8] <= hwData[8*lane +: 8];
                end
            end
        end
    end

    // Whole word back on reads
    assign hrData = mem[dataIndex];

endmodule

// File: source/ahbMemorySubsystem.sv
// Shared AHB memory port

`timescale 1ns/1ps

module ahbMemorySubsystem #(
    parameter int waitStates = 2,
    parameter int memWords   = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    input  ahbBusPkg::masterReq             reqT,
    input  ahbBusPkg::masterReq             reqM,
    input  ahbBusPkg::masterReq             reqF,
    input  logic [ahbBusPkg::dataWidth-1:0] hwDataM,
    output logic                            grantT,
    output logic                            grantM,
    output logic                            grantF,
    output logic                            readyT,
    output logic                            readyM,
    output logic                            readyF,
    output logic [ahbBusPkg::dataWidth-1:0] hrData
);

    // Shared bus between arbiter and slave
    logic [31:0]                     haddr;
    logic                            htrans;
    logic                            hwrite;
    logic [2:0]                      hsize;
    logic [ahbBusPkg::dataWidth-1:0] hwData;
    logic                            hready;

    ahbArbiter arbiter (
        .clk     (clk),
        .reset   (reset),
        .reqT    (reqT),
        .reqM    (reqM),
        .reqF    (reqF),
        .hwDataM (hwDataM),
        .hready  (hready),
        .grantT  (grantT),
        .grantM  (grantM),
        .grantF  (grantF),
        .readyT  (readyT),
        .readyM  (readyM),
        .readyF  (readyF),
        .haddr   (haddr),
        .htrans  (htrans),
        .hwrite  (hwrite),
        .hsize   (hsize),
        .hwData  (hwData)
    );

    ahbWaitMemory #(
        .waitStates (waitStates),
        .memWords   (memWords)
    ) memory (
        .clk    (clk),
        .reset  (reset),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwData (hwData),
        .hready (hready),
        .hrData (hrData)
    );

endmodule

// File: test/ahbMemorySubsystemTb.sv
// Memory subsystem testbench

`timescale 1ns/1ps

module ahbMemorySubsystemTb;

    localparam int waitStates = 2;
    localparam int memWords   = 256;
    localparam int fieldCount = 10;
    localparam int maxLines   = 64;
    localparam int waitLimit  = 200;

    logic                clk;
    logic                reset;
    ahbBusPkg::masterReq reqT;
    ahbBusPkg::masterReq reqM;
    ahbBusPkg::masterReq reqF;
    logic [31:0]         hwDataM;
    logic                grantT, grantM, grantF;
    logic                readyT, readyM, readyF;
    logic [31:0]         hrData;

    // Ten hex words per pattern line
    logic [31:0] patterns [maxLines*fieldCount];
    // Expected memory contents
    logic [31:0] shadow [memWords];

    int   errorCount;
    int   readyOrder[$];
    logic anyAccepted;
    logic prevHready;
    logic [2:0] prevGrants;

    ahbMemorySubsystem #(
        .waitStates (waitStates),
        .memWords   (memWords)
    ) uut (
        .clk     (clk),
        .reset   (reset),
        .reqT    (reqT),
        .reqM    (reqM),
        .reqF    (reqF),
        .hwDataM (hwDataM),
        .grantT  (grantT),
        .grantM  (grantM),
        .grantF  (grantF),
        .readyT  (readyT),
        .readyM  (readyM),
        .readyF  (readyF),
        .hrData  (hrData)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s actual=%h expected=%h",
                     $time, name, actual, expected);
            errorCount++;
        end
    endtask

    function automatic int wordIndex(input logic [31:0] addr);
        return int'((addr >> 2) % memWords);
    endfunction

    // Lanes follow the transfer size aligned down inside the word
    task automatic writeShadow(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] data);
        int bytes;
        int first;
        int lane;
        int index;
        bytes = 1 << size;
        first = int'(addr[1:0]) & ~(bytes - 1);
        index = wordIndex(addr);
        for (lane = 0; lane < 4; lane++) begin
            if (lane >= first && lane < first + bytes) begin
                shadow[index][8*lane +: 8] = data[8*lane +: 8];
            end
        end
    endtask

    // Service order is T, M, F, so F sees the write of M
    task automatic predictLine(input int base);
        logic [31:0] flags;
        flags = patterns[base];
        if (flags[8]) begin
            checkValue("shadow T", shadow[wordIndex(patterns[base+1])], patterns[base+7]);
        end
        if (flags[4]) begin
            if (patterns[base+4][0]) begin
                writeShadow(patterns[base+2], patterns[base+5][2:0], patterns[base+6]);
            end else begin
                checkValue("shadow M", shadow[wordIndex(patterns[base+2])], patterns[base+8]);
            end
        end
        if (flags[0]) begin
            checkValue("shadow F", shadow[wordIndex(patterns[base+3])], patterns[base+9]);
        end
    endtask

    task automatic setRequest(input int who, input ahbBusPkg::masterReq value);
        case (who)
            0:       reqT <= value;
            1:       reqM <= value;
            default: reqF <= value;
        endcase
    endtask

    function automatic logic grantOf(input int who);
        case (who)
            0:       return grantT;
            1:       return grantM;
            default: return grantF;
        endcase
    endfunction

    function automatic logic readyOf(input int who);
        case (who)
            0:       return readyT;
            1:       return readyM;
            default: return readyF;
        endcase
    endfunction

    // One master through request, acceptance, data phase and check
    task automatic runMaster(input int who, input logic [31:0] addr, input logic write,
                             input logic [2:0] size, input logic [31:0] expected);
        ahbBusPkg::masterReq req;
        string tag;
        logic  granted;
        logic  done;
        int    waited;
        int    cycles;
        tag         = (who == 0) ? "T" : ((who == 1) ? "M" : "F");
        req.request = 1'b1;
        req.write   = write;
        req.size    = size;
        req.addr    = addr;
        granted     = 1'b0;
        waited      = 0;
        setRequest(who, req);
        while (!granted && waited < waitLimit) begin
            @(negedge clk);
            if (grantOf(who) && uut.hready) begin
                granted = 1'b1;
            end else begin
                waited++;
            end
        end
        // Address taken at this edge
        @(posedge clk);
        req.request = 1'b0;
        setRequest(who, req);
        if (!granted) begin
            $display("Timeout: master %s was never granted the bus", tag);
            errorCount++;
        end else begin
            anyAccepted = 1'b1;
            done        = 1'b0;
            cycles      = 0;
            while (!done && cycles < waitLimit) begin
                @(negedge clk);
                cycles++;
                if (readyOf(who)) begin
                    done = 1'b1;
                end
            end
            if (!done) begin
                $display("Timeout: master %s never saw its data phase end", tag);
                errorCount++;
            end else begin
                checkValue({"latency ", tag}, 32'(cycles), 32'(waitStates + 1));
                if (!write) begin
                    checkValue({"hrData for ", tag}, hrData, expected);
                end
            end
        end
    endtask

    // Ready pulses must come in priority order, once each
    task automatic checkOrder(input logic useT, input logic useM, input logic useF);
        int expected[$];
        int slot;
        if (useT) expected.push_back(0);
        if (useM) expected.push_back(1);
        if (useF) expected.push_back(2);
        checkValue("ready pulse count", 32'(readyOrder.size()), 32'(expected.size()));
        for (slot = 0; slot < expected.size() && slot < readyOrder.size(); slot++) begin
            checkValue("ready order", 32'(readyOrder[slot]), 32'(expected[slot]));
        end
    endtask

    // Bus watcher sampled mid-cycle
    always @(negedge clk) begin
        if (!anyAccepted) begin
            checkValue("readies before first transfer", 32'({readyT, readyM, readyF}), 32'd0);
        end
        if (!reset) begin
            // Frozen state while the slave stalls
            if (!prevHready) begin
                checkValue("grants during wait", 32'({grantT, grantM, grantF}),
                           32'(prevGrants));
            end
            if (readyT) readyOrder.push_back(0);
            if (readyM) readyOrder.push_back(1);
            if (readyF) readyOrder.push_back(2);
            prevHready = uut.hready;
            prevGrants = {grantT, grantM, grantF};
        end
    end

    initial begin
        int          lineIdx;
        int          base;
        int          gap;
        int          errorsBefore;
        int          passedTests;
        int          failedTests;
        logic [31:0] flags;
        logic        useT, useM, useF;
        string       label;
        clk         = 1'b0;
        reset       = 1'b1;
        reqT        = '0;
        reqM        = '0;
        reqF        = '0;
        hwDataM     = '0;
        errorCount  = 0;
        passedTests = 0;
        failedTests = 0;
        anyAccepted = 1'b0;
        prevHready  = 1'b1;
        prevGrants  = 3'b000;
        void'($urandom(32'h8d47783e));
        $readmemh("test/ahbBusPatterns.txt", patterns);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Quiet stretch with readies held low
        repeat (4) @(posedge clk);
        lineIdx = 0;
        flags   = patterns[0];
        while (lineIdx < maxLines && flags != 32'h0 && flags != 32'hfff) begin
            base  = lineIdx * fieldCount;
            useT  = flags[8];
            useM  = flags[4];
            useF  = flags[0];
            label = $sformatf("%s%s%s", useT ? "T" : "", useM ? "M" : "", useF ? "F" : "");
            errorsBefore = errorCount;
            predictLine(base);
            @(posedge clk);
            if (useM) begin
                hwDataM <= patterns[base+6];
            end
            // All requesters rise on the same edge
            fork
                if (useT) runMaster(0, patterns[base+1], 1'b0, ahbBusPkg::sizeWord,
                                    patterns[base+7]);
                if (useM) runMaster(1, patterns[base+2], patterns[base+4][0],
                                    patterns[base+5][2:0], patterns[base+8]);
                if (useF) runMaster(2, patterns[base+3], 1'b0, ahbBusPkg::sizeWord,
                                    patterns[base+9]);
            join
            @(posedge clk);
            checkOrder(useT, useM, useF);
            readyOrder.delete();
            if (errorCount == errorsBefore) begin
                passedTests++;
                $display("Test %0d %s: ok", lineIdx + 1, label);
            end else begin
                failedTests++;
                $display("Test %0d %s: %0d errors", lineIdx + 1, label,
                         errorCount - errorsBefore);
            end
            gap = int'($urandom % 4);
            repeat (gap) @(posedge clk);
            lineIdx++;
            flags = (lineIdx < maxLines) ? patterns[lineIdx * fieldCount] : 32'h0;
        end
        $display("Summary: %0d passed, %0d failed, %0d errors",
                 passedTests, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: ahbMemorySubsystem.f
source/ahbBusPkg.sv
source/ahbArbiterController.sv
source/ahbArbiter.sv
source/ahbWaitMemory.sv
source/ahbMemorySubsystem.sv
test/ahbMemorySubsystemTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module ahbMemorySubsystemTb \
    -f ahbMemorySubsystem.f -o simv > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 \
    || { echo "simulation error, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: test/ahbBusPatterns.txt
// flags(T M F as hex digits) addrT addrM addrF writeM sizeM wdataM expT expM expF
// sizes 0 byte, 1 half, 2 word; a line of fff ends the list
// Preload by M word writes
010 00000000 00000000 00000000 1 2 11223344 00000000 00000000 00000000
010 00000000 00000004 00000000 1 2 55667788 00000000 00000000 00000000
010 00000000 00000008 00000000 1 2 99aabbcc 00000000 00000000 00000000
010 00000000 0000000c 00000000 1 2 ddeeff00 00000000 00000000 00000000
010 00000000 00000010 00000000 1 2 0badf00d 00000000 00000000 00000000
010 00000000 00000014 00000000 1 2 cafe1234 00000000 00000000 00000000
010 00000000 00000020 00000000 1 2 a5a5a5a5 00000000 00000000 00000000
010 00000000 00000024 00000000 1 2 5a5a5a5a 00000000 00000000 00000000
010 00000000 00000100 00000000 1 2 01020304 00000000 00000000 00000000
010 00000000 00000104 00000000 1 2 0f0e0d0c 00000000 00000000 00000000
// Each master alone
100 00000000 00000000 00000000 0 2 00000000 11223344 00000000 00000000
010 00000000 00000004 00000000 0 2 00000000 00000000 55667788 00000000
001 00000000 00000000 00000008 0 2 00000000 00000000 00000000 99aabbcc
// Narrow writes with junk in the unused lanes
010 00000000 00000011 00000000 1 0 ffff77ff 00000000 00000000 00000000
010 00000000 00000016 00000000 1 1 beef9999 00000000 00000000 00000000
010 00000000 00000018 00000000 1 2 13579bdf 00000000 00000000 00000000
010 00000000 00000013 00000000 1 0 42aaaaaa 00000000 00000000 00000000
100 00000010 00000000 00000000 0 2 00000000 42ad770d 00000000 00000000
001 00000000 00000000 00000014 0 2 00000000 00000000 00000000 beef1234
100 00000018 00000000 00000000 0 2 00000000 13579bdf 00000000 00000000
010 00000000 00000010 00000000 1 1 1111c0de 00000000 00000000 00000000
001 00000000 00000000 00000010 0 2 00000000 00000000 00000000 42adc0de
// All three at once
111 00000000 00000004 00000008 0 2 00000000 11223344 55667788 99aabbcc
// T reads before the write of M, F after it
111 0000000c 0000000c 0000000c 1 2 600dcafe ddeeff00 00000000 600dcafe
111 00000020 00000024 00000100 0 2 00000000 a5a5a5a5 5a5a5a5a 01020304
// Pairs
110 00000104 00000000 00000000 0 2 00000000 0f0e0d0c 11223344 00000000
101 00000004 00000000 00000018 0 2 00000000 55667788 00000000 13579bdf
011 00000000 00000014 00000020 0 2 00000000 00000000 beef1234 a5a5a5a5
110 00000024 00000026 00000000 1 0 00ee0000 5a5a5a5a 00000000 00000000
011 00000000 00000104 00000104 1 1 00004321 00000000 00000000 0f0e4321
101 00000024 00000000 00000104 0 2 00000000 5aee5a5a 00000000 0f0e4321
// Address 400 wraps onto word 0
111 00000400 00000008 00000008 1 0 000000ee 11223344 00000000 99aabbee
fff
